//--- Bender.yml
package:
  name: ccu

sources:
  - source/isa_pkg.sv
  - source/cfg_pkg.sv
  - source/isa_fetch.sv
  - source/isa_decode.sv
  - source/cfg_slot.sv
  - source/ccu_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/ccu_tb.sv

//--- sim/ccu_tb_ref.svh
// Reference model for the configuration unit testbench
// Included inside ccu_tb, relies on its package imports, POOL_CORE and seed
// Expected values are unpacked from the word format alone
// Image is at most IMG_LEN words, unit word at address 0
`ifndef CCU_TB_REF_SVH
`define CCU_TB_REF_SVH

localparam int         IMG_LEN     = 48;
localparam logic [7:0] REF_OPC_CCU = 8'd0;
localparam logic [7:0] REF_OPC_SYA = 8'd1;
localparam logic [7:0] REF_OPC_POL = 8'd2;

isa_word_t img [IMG_LEN];
int        nsya;       // Array blocks in the image, also the layer count
int        npol_blk;   // Complete pool blocks in the image

// ======================================================================
// Image builder
// ======================================================================
task automatic build_image();
    int         r;
    int         npol_words;
    logic [7:0] opc;
    nsya       = 0;
    npol_words = 0;
    for (int i = 0; i < IMG_LEN; i++) begin
        for (int j = 0; j < 8; j++) begin
            img[i][32*j +: 32] = $random(seed);
        end
        r = $unsigned($random(seed)) % 16;
        if (i == 1 || r < 6) opc = REF_OPC_SYA;   // At least one array block
        else if (r < 13) opc = REF_OPC_POL;
        else if (r == 13) opc = REF_OPC_CCU;      // Stray unit word, never read
        else opc = 8'hC3;                         // Unknown opcode
        if (i == 0) opc = REF_OPC_CCU;
        img[i][7:0] = opc;
        if (i != 0 && opc == REF_OPC_SYA) nsya++;
        if (opc == REF_OPC_POL) npol_words++;
    end
    npol_blk       = npol_words / 3;
    img[0][27:8]   = nsya[19:0];   // Layer count
endtask

// k-th array block, fields from bit 8 in format order
function automatic sya_cfg_t expected_sya(input int k);
    sya_cfg_t  c;
    isa_word_t w;
    int        n;
    c = '0;
    n = 0;
    for (int i = 0; i < IMG_LEN; i++) begin
        if (img[i][7:0] == REF_OPC_SYA) begin
            w = img[i];
            if (n == k) begin
                c.mode     = w[15:8];
                c.nip      = w[31:16];
                c.chi      = w[43:32];
                c.scale    = w[63:44];
                c.shift    = w[71:64];
                c.zp       = w[79:72];
                c.act_base = w[95:80];
                c.wgt_base = w[111:96];
                c.ofm_base = w[127:112];
            end
            n++;
        end
    end
    return c;
endfunction

// k-th pool block: points, channels, then k, core 0 lowest
function automatic pol_bank_t expected_pol(input int k);
    pol_bank_t b;
    isa_word_t w;
    int        n;
    b = '0;
    n = 0;
    for (int i = 0; i < IMG_LEN; i++) begin
        if (img[i][7:0] == REF_OPC_POL) begin
            w = img[i];
            if (n / 3 == k) begin
                for (int c = 0; c < POOL_CORE; c++) begin
                    case (n % 3)
                        0:       b[c].nip = w[8 + 16*c +: 16];
                        1:       b[c].chn = w[8 + 12*c +: 12];
                        default: b[c].k   = w[8 + 8*c +: 8];
                    endcase
                end
            end
            n++;
        end
    end
    return b;
endfunction

// Image index just past the nblk-th block of one opcode, 0 if none read
function automatic int ptr_after(input logic [7:0] opc, input int words, input int nblk);
    int n;
    int p;
    n = 0;
    p = 0;
    for (int i = 0; i < IMG_LEN; i++) begin
        if (img[i][7:0] == opc) begin
            n++;
            if (n == nblk * words) p = i + 1;
        end
    end
    return p;
endfunction

function automatic int expected_addr_min(input int sya_done, input int pol_done);
    int m;
    int p;
    m = ptr_after(REF_OPC_CCU, 1, 1);
    p = ptr_after(REF_OPC_SYA, 1, sya_done);
    if (p < m) m = p;
    p = ptr_after(REF_OPC_POL, 3, pol_done);
    if (p < m) m = p;
    return m;
endfunction

`endif

//--- sim/ccu_tb.sv
// Testbench for the configuration control unit
// RAM model serves one read at a time, data 1 to 4 cycles after the address
// Target models accept at random, the first pool config of a run is held back
// Two networks run back to back from the same image
`default_nettype none

module ccu_tb;
    import isa_pkg::*;
    import cfg_pkg::*;

    localparam int POOL_CORE   = 6;
    localparam int RAM_DEPTH   = 64;
    localparam int POOL_STALL  = 40;      // Cycles the first pool config waits
    localparam int RUN_TIMEOUT = 20000;

    typedef pol_cfg_t [POOL_CORE-1:0] pol_bank_t;

    logic                  clk;
    logic                  rst_n;
    logic                  start_i;
    logic                  net_done_o;
    logic [ADDR_WIDTH-1:0] rd_addr_o;
    logic                  rd_addr_vld_o;
    logic                  rd_addr_rdy_i;
    isa_word_t             rd_dat_i;
    logic                  rd_dat_vld_i;
    logic                  rd_dat_rdy_o;
    logic [ADDR_WIDTH-1:0] isa_addr_min_o;
    logic                  sya_rst_o;
    logic                  sya_cfg_vld_o;
    logic                  sya_cfg_rdy_i;
    sya_cfg_t              sya_cfg_o;
    logic [POOL_CORE-1:0]  pol_rst_o;
    logic [POOL_CORE-1:0]  pol_cfg_vld_o;
    logic [POOL_CORE-1:0]  pol_cfg_rdy_i;
    pol_bank_t             pol_cfg_o;

    integer                seed;
    integer                rnd;
    int                    value_errs;
    int                    other_errs;
    bit                    aborted;
    int                    run_no;
    int                    sya_cnt;
    int                    pol_cnt;
    int                    pol_wait;
    int                    done_cycles;
    bit                    done_seen;
    isa_word_t             mem [RAM_DEPTH];
    bit                    addr_hs;
    bit                    dat_hs;
    bit                    pol_held;
    bit                    pol_go;
    bit                    ram_busy;
    logic [ADDR_WIDTH-1:0] addr_smp;
    logic [ADDR_WIDTH-1:0] ram_addr;
    int                    ram_wait;

    `include "ccu_tb_ref.svh"

    ccu_top #(.POOL_CORE(POOL_CORE)) i_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .start_i       (start_i),
        .net_done_o    (net_done_o),
        .rd_addr_o     (rd_addr_o),
        .rd_addr_vld_o (rd_addr_vld_o),
        .rd_addr_rdy_i (rd_addr_rdy_i),
        .rd_dat_i      (rd_dat_i),
        .rd_dat_vld_i  (rd_dat_vld_i),
        .rd_dat_rdy_o  (rd_dat_rdy_o),
        .isa_addr_min_o(isa_addr_min_o),
        .sya_rst_o     (sya_rst_o),
        .sya_cfg_vld_o (sya_cfg_vld_o),
        .sya_cfg_rdy_i (sya_cfg_rdy_i),
        .sya_cfg_o     (sya_cfg_o),
        .pol_rst_o     (pol_rst_o),
        .pol_cfg_vld_o (pol_cfg_vld_o),
        .pol_cfg_rdy_i (pol_cfg_rdy_i),
        .pol_cfg_o     (pol_cfg_o)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic check_value(input string name, input logic [255:0] exp,
                               input logic [255:0] act);
        assert (act === exp) else begin
            value_errs++;
            $display("FAIL %s: expected %0h, actual %0h", name, exp, act);
        end
    endtask

    task automatic report_and_finish();
        $display("Errors: %0d wrong values, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0 && !aborted) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    endtask

    // ======================================================================
    // RAM and target ready drivers, all random draws in one fixed order
    // ======================================================================
    always @(posedge clk) begin
        // Data ready must follow the single outstanding read
        assert (rd_dat_rdy_o === ram_busy) else begin
            other_errs++;
            $display("ERROR RAM data ready is %0b while a read outstanding is %0b",
                     rd_dat_rdy_o, ram_busy);
        end
        addr_hs  = rd_addr_vld_o && rd_addr_rdy_i;
        dat_hs   = rd_dat_vld_i && rd_dat_rdy_o;
        addr_smp = rd_addr_o;
        pol_held = pol_cfg_vld_o[0] && !(&pol_cfg_rdy_i);
        #1;
        if (dat_hs) begin
            rd_dat_vld_i = 1'b0;
            ram_busy     = 1'b0;
        end
        if (addr_hs) begin
            ram_busy = 1'b1;
            ram_addr = addr_smp;
            ram_wait = $unsigned($random(seed)) % 4;
        end else if (ram_busy && ram_wait != 0) begin
            ram_wait--;
        end
        if (ram_busy && !rd_dat_vld_i && ram_wait == 0) begin
            rd_dat_vld_i = 1'b1;
            rd_dat_i     = mem[ram_addr];
        end
        rnd           = $random(seed);
        rd_addr_rdy_i = rnd[0];
        sya_cfg_rdy_i = rnd[1];
        pol_go        = rnd[2] && (pol_cnt < npol_blk);   // No pool blocks past the image
        if (pol_held) pol_wait++;
        if (pol_cnt == 0 && pol_cfg_vld_o[0] && pol_wait < POOL_STALL) pol_go = 1'b0;
        pol_cfg_rdy_i = {POOL_CORE{pol_go}};
    end

    // ======================================================================
    // Target models and comparison
    // ======================================================================
    always @(posedge clk) begin
        if (rst_n) begin
            assert (!(done_seen && (sya_cfg_vld_o || |pol_cfg_vld_o))) else begin
                other_errs++;
                $display("ERROR configuration valid raised after net_done in run %0d", run_no);
            end
            if (sya_cfg_vld_o && sya_cfg_rdy_i) begin
                check_value($sformatf("run %0d sya cfg %0d", run_no, sya_cnt),
                            expected_sya(sya_cnt), sya_cfg_o);
                sya_cnt++;
            end
            if (pol_cfg_vld_o[0] && &pol_cfg_rdy_i) begin
                check_value($sformatf("run %0d pol cfg %0d", run_no, pol_cnt),
                            expected_pol(pol_cnt), pol_cfg_o);
                pol_cnt++;
            end
            if (net_done_o) begin
                done_cycles++;
                done_seen = 1'b1;
                check_value($sformatf("run %0d addr_min", run_no),
                            expected_addr_min(sya_cnt, pol_cnt), isa_addr_min_o);
            end
        end
    end

    task automatic run_network(input int run);
        int waited;
        run_no      = run;
        sya_cnt     = 0;
        pol_cnt     = 0;
        pol_wait    = 0;
        done_cycles = 0;
        done_seen   = 1'b0;
        start_i     = 1'b1;
        @(posedge clk);
        #1 start_i = 1'b0;
        waited = 0;
        while ((sya_rst_o || |pol_rst_o) && waited < 2) begin
            @(posedge clk);
            #1 waited++;
        end
        assert (!sya_rst_o && !(|pol_rst_o)) else begin
            other_errs++;
            $display("ERROR target resets still high 2 cycles after start in run %0d", run);
        end
        waited = 0;
        while (!done_seen && waited < RUN_TIMEOUT) begin
            @(posedge clk);
            #1 waited++;
        end
        assert (done_seen) else begin
            other_errs++;
            aborted = 1'b1;
            $display("ERROR net_done never came within %0d cycles in run %0d", waited, run);
        end
        if (!aborted) begin
            for (int i = 0; i < 30; i++) begin
                @(posedge clk);
            end
            #1;
            check_value($sformatf("run %0d net_done cycles", run), 1, done_cycles);
            check_value($sformatf("run %0d sya configs", run), nsya, sya_cnt);
            check_value($sformatf("run %0d sya_rst in idle", run), 1, sya_rst_o);
            check_value($sformatf("run %0d pol_rst in idle", run), {POOL_CORE{1'b1}},
                        pol_rst_o);
        end
    endtask

    initial begin
        seed          = 32'h4368;
        value_errs    = 0;
        other_errs    = 0;
        aborted       = 1'b0;
        run_no        = 0;
        sya_cnt       = 0;
        pol_cnt       = 0;
        pol_wait      = 0;
        done_cycles   = 0;
        done_seen     = 1'b0;
        ram_busy      = 1'b0;
        ram_wait      = 0;
        ram_addr      = '0;
        rst_n         = 1'b0;
        start_i       = 1'b0;
        rd_addr_rdy_i = 1'b0;
        rd_dat_i      = '0;
        rd_dat_vld_i  = 1'b0;
        sya_cfg_rdy_i = 1'b0;
        pol_cfg_rdy_i = '0;
        build_image();
        for (int a = 0; a < RAM_DEPTH; a++) begin
            mem[a]       = {16{16'(a) ^ 16'h5A5A}};   // Fill beyond the image
            mem[a][7:0]  = 8'hEE;
            if (a < IMG_LEN) mem[a] = img[a];
        end
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
        check_value("reset rd_addr_vld", 0, rd_addr_vld_o);
        check_value("reset sya_cfg_vld", 0, sya_cfg_vld_o);
        check_value("reset pol_cfg_vld", 0, pol_cfg_vld_o);
        check_value("reset net_done", 0, net_done_o);
        check_value("reset sya_rst", 1, sya_rst_o);
        check_value("reset pol_rst", {POOL_CORE{1'b1}}, pol_rst_o);
        for (int run = 0; run < 2; run++) begin
            if (!aborted) run_network(run);   // Second run replays from address 0
        end
        report_and_finish();
    end

endmodule

`default_nettype wire

//--- source/ccu_top.sv
// Configuration control unit for the point-cloud accelerator
// Pool cores share one valid and one reset, ready is the AND of all cores
// isa_addr_min_o is the lowest RAM address still needed by any target
`default_nettype none

module ccu_top #(
    parameter int POOL_CORE = 6
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              start_i,
    output logic                              net_done_o,
    output logic [isa_pkg::ADDR_WIDTH-1:0]    rd_addr_o,
    output logic                              rd_addr_vld_o,
    input  logic                              rd_addr_rdy_i,
    input  isa_pkg::isa_word_t                rd_dat_i,
    input  logic                              rd_dat_vld_i,
    output logic                              rd_dat_rdy_o,
    output logic [isa_pkg::ADDR_WIDTH-1:0]    isa_addr_min_o,
    output logic                              sya_rst_o,
    output logic                              sya_cfg_vld_o,
    input  logic                              sya_cfg_rdy_i,
    output cfg_pkg::sya_cfg_t                 sya_cfg_o,
    output logic [POOL_CORE-1:0]              pol_rst_o,
    output logic [POOL_CORE-1:0]              pol_cfg_vld_o,
    input  logic [POOL_CORE-1:0]              pol_cfg_rdy_i,
    output cfg_pkg::pol_cfg_t [POOL_CORE-1:0] pol_cfg_o
);
    import isa_pkg::*;
    import cfg_pkg::*;

    typedef pol_cfg_t [POOL_CORE-1:0] pol_bank_t;

    isa_beat_t                  beat;
    logic                       block_done;
    logic                       ccu_taken;
    logic [NUM_LAYER_WIDTH-1:0] num_layers;
    logic                       sya_load;
    logic                       sya_taken;
    sya_cfg_t                   sya_cfg_dec;
    logic                       pol_load;
    logic                       pol_taken;
    logic                       pol_vld;
    pol_bank_t                  pol_cfg_dec;
    logic [NUM_TARGET-1:1]      tgt_rst;

    // ======================================================================
    // Fetch and decode
    // ======================================================================
    isa_fetch i_fetch (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (start_i),
        .sya_rdy_i    (sya_cfg_rdy_i),
        .pol_rdy_i    (&pol_cfg_rdy_i),
        .sya_taken_i  (sya_taken),
        .pol_taken_i  (pol_taken),
        .block_done_i (block_done),
        .ccu_taken_i  (ccu_taken),
        .num_layers_i (num_layers),
        .rd_addr_o    (rd_addr_o),
        .rd_addr_vld_o(rd_addr_vld_o),
        .rd_addr_rdy_i(rd_addr_rdy_i),
        .rd_dat_i     (rd_dat_i),
        .rd_dat_vld_i (rd_dat_vld_i),
        .rd_dat_rdy_o (rd_dat_rdy_o),
        .beat_o       (beat),
        .tgt_rst_o    (tgt_rst),
        .addr_min_o   (isa_addr_min_o),
        .net_done_o   (net_done_o)
    );

    isa_decode #(.POOL_CORE(POOL_CORE)) i_decode (
        .clk          (clk),
        .rst_n        (rst_n),
        .beat_i       (beat),
        .block_done_o (block_done),
        .ccu_taken_o  (ccu_taken),
        .num_layers_o (num_layers),
        .sya_load_o   (sya_load),
        .sya_cfg_o    (sya_cfg_dec),
        .pol_load_o   (pol_load),
        .pol_cfg_o    (pol_cfg_dec)
    );

    // ======================================================================
    // Target slots
    // ======================================================================
    cfg_slot #(.cfg_t(sya_cfg_t)) i_sya_slot (
        .clk      (clk),
        .rst_n    (rst_n),
        .load_i   (sya_load),
        .cfg_i    (sya_cfg_dec),
        .cfg_o    (sya_cfg_o),
        .cfg_vld_o(sya_cfg_vld_o),
        .cfg_rdy_i(sya_cfg_rdy_i),
        .taken_o  (sya_taken)
    );

    // Ready toward the slot is the AND of all pool cores
    cfg_slot #(.cfg_t(pol_bank_t)) i_pol_slot (
        .clk      (clk),
        .rst_n    (rst_n),
        .load_i   (pol_load),
        .cfg_i    (pol_cfg_dec),
        .cfg_o    (pol_cfg_o),
        .cfg_vld_o(pol_vld),
        .cfg_rdy_i(&pol_cfg_rdy_i),
        .taken_o  (pol_taken)
    );

    assign pol_cfg_vld_o = {POOL_CORE{pol_vld}};
    assign sya_rst_o     = tgt_rst[OPC_SYA];
    assign pol_rst_o     = {POOL_CORE{tgt_rst[OPC_POL]}};

endmodule

`default_nettype wire

//--- source/cfg_pkg.sv
// Configuration payloads handed to the array and pool targets
// Array struct is laid out so that mode lands at the lowest bits,
// matching the word image from bit 8 upward
// Pool payload is an array of pol_cfg_t, one per core
`default_nettype none

package cfg_pkg;

    localparam int IDX_WIDTH   = 16;
    localparam int CHN_WIDTH   = 12;
    localparam int QNTSL_WIDTH = 20;
    localparam int ACT_WIDTH   = 8;
    localparam int K_WIDTH     = 8;

    // ======================================================================
    // Systolic array, 120 bits, first member is the MSB
    // ======================================================================
    typedef struct packed {
        logic [isa_pkg::ADDR_WIDTH-1:0] ofm_base;   // Output write base
        logic [isa_pkg::ADDR_WIDTH-1:0] wgt_base;   // Weight read base
        logic [isa_pkg::ADDR_WIDTH-1:0] act_base;   // Activation read base
        logic [ACT_WIDTH-1:0]           zp;
        logic [ACT_WIDTH-1:0]           shift;
        logic [QNTSL_WIDTH-1:0]         scale;
        logic [CHN_WIDTH-1:0]           chi;        // Input channels
        logic [IDX_WIDTH-1:0]           nip;        // Points
        logic [7:0]                     mode;
    } sya_cfg_t;

    // ======================================================================
    // One pool core
    // ======================================================================
    typedef struct packed {
        logic [K_WIDTH-1:0]   k;
        logic [CHN_WIDTH-1:0] chn;
        logic [IDX_WIDTH-1:0] nip;
    } pol_cfg_t;

endpackage

`default_nettype wire

//--- source/cfg_slot.sv
// One-entry configuration holder toward a target
// Payload is captured on load and held until the target takes it
// A load is never issued while the slot is still valid
`default_nettype none

module cfg_slot #(
    parameter type cfg_t = logic
) (
    input  logic clk,
    input  logic rst_n,
    input  logic load_i,
    input  cfg_t cfg_i,
    output cfg_t cfg_o,
    output logic cfg_vld_o,
    input  logic cfg_rdy_i,
    output logic taken_o
);

    assign taken_o = cfg_vld_o && cfg_rdy_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_vld_o <= 1'b0;
        end else if (load_i) begin
            cfg_vld_o <= 1'b1;
        end else if (taken_o) begin
            cfg_vld_o <= 1'b0;   // Drops the cycle after transfer
        end
    end

    // Payload register
    always_ff @(posedge clk) begin
        if (load_i) cfg_o <= cfg_i;
    end

endmodule

`default_nettype wire

//--- source/isa_decode.sv
// Decode side: opcode match, word counting and field extraction
// Beats whose opcode differs from their target index are dropped
// Pool words 1 and 2 are held here, word 3 completes the payload
// Loads and block_done are combinational on the last matching beat
`default_nettype none

module isa_decode #(
    parameter int POOL_CORE = 6   // 1 to 12 cores fit in one word
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  isa_pkg::isa_beat_t                  beat_i,
    output logic                                block_done_o,
    output logic                                ccu_taken_o,
    output logic [isa_pkg::NUM_LAYER_WIDTH-1:0] num_layers_o,
    output logic                                sya_load_o,
    output cfg_pkg::sya_cfg_t                   sya_cfg_o,
    output logic                                pol_load_o,
    output cfg_pkg::pol_cfg_t [POOL_CORE-1:0]   pol_cfg_o
);
    import isa_pkg::*;
    import cfg_pkg::*;

    logic [OPCODE_WIDTH-1:0]             opcode;
    logic                                match;
    logic                                last;
    logic [1:0]                          word_cnt_q;
    logic [POOL_CORE-1:0][IDX_WIDTH-1:0] pol_nip_q;
    logic [POOL_CORE-1:0][CHN_WIDTH-1:0] pol_chn_q;

    // ======================================================================
    // Match and word count
    // ======================================================================
    assign opcode = beat_i.word[OPCODE_WIDTH-1:0];
    assign match  = beat_i.vld && (opcode == OPCODE_WIDTH'(beat_i.tgt));
    assign last   = (word_cnt_q == WORDS_PER_OPC[beat_i.tgt] - 2'd1);

    assign block_done_o = match && last;
    assign ccu_taken_o  = block_done_o && (beat_i.tgt == OPC_CCU);
    assign sya_load_o   = block_done_o && (beat_i.tgt == OPC_SYA);
    assign pol_load_o   = block_done_o && (beat_i.tgt == OPC_POL);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_cnt_q   <= '0;
            num_layers_o <= '0;
        end else if (match) begin
            word_cnt_q <= last ? 2'd0 : word_cnt_q + 2'd1;
            if (beat_i.tgt == OPC_CCU) begin
                num_layers_o <= beat_i.word[OPCODE_WIDTH +: NUM_LAYER_WIDTH];
            end
        end
    end

    // ======================================================================
    // Field extraction
    // ======================================================================
    // Single array word, fields packed from bit 8
    assign sya_cfg_o = beat_i.word[OPCODE_WIDTH +: $bits(sya_cfg_t)];

    always_ff @(posedge clk) begin
        if (match && beat_i.tgt == OPC_POL) begin
            if (word_cnt_q == 2'd0) begin
                pol_nip_q <= beat_i.word[OPCODE_WIDTH +: POOL_CORE * IDX_WIDTH];
            end
            if (word_cnt_q == 2'd1) begin
                pol_chn_q <= beat_i.word[OPCODE_WIDTH +: POOL_CORE * CHN_WIDTH];
            end
        end
    end

    for (genvar c = 0; c < POOL_CORE; c++) begin : g_core
        assign pol_cfg_o[c].nip = pol_nip_q[c];
        assign pol_cfg_o[c].chn = pol_chn_q[c];
        assign pol_cfg_o[c].k   = beat_i.word[OPCODE_WIDTH + c * K_WIDTH +: K_WIDTH];   // Word 3
    end

endmodule

`default_nettype wire

//--- source/isa_fetch.sv
// Fetch side of the configuration unit: FSM, target pick, RAM reads
// Only one RAM read is outstanding at a time
// Per-target pointers restart at address 0 whenever the FSM is idle
// Layer count is the number of accepted array configurations
`default_nettype none

module isa_fetch (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 start_i,
    input  logic                                 sya_rdy_i,
    input  logic                                 pol_rdy_i,    // AND of all pool cores
    input  logic                                 sya_taken_i,
    input  logic                                 pol_taken_i,
    input  logic                                 block_done_i,
    input  logic                                 ccu_taken_i,
    input  logic [isa_pkg::NUM_LAYER_WIDTH-1:0]  num_layers_i,
    output logic [isa_pkg::ADDR_WIDTH-1:0]       rd_addr_o,
    output logic                                 rd_addr_vld_o,
    input  logic                                 rd_addr_rdy_i,
    input  isa_pkg::isa_word_t                   rd_dat_i,
    input  logic                                 rd_dat_vld_i,
    output logic                                 rd_dat_rdy_o,
    output isa_pkg::isa_beat_t                   beat_o,
    output logic [isa_pkg::NUM_TARGET-1:1]       tgt_rst_o,    // Indexed by target
    output logic [isa_pkg::ADDR_WIDTH-1:0]       addr_min_o,
    output logic                                 net_done_o
);
    import isa_pkg::*;

    ccu_state_t                             state_q;
    ccu_state_t                             state_d;
    logic [NUM_TARGET-1:0]                  tgt_rdy;
    target_idx_t                            pick;
    target_idx_t                            sel_q;
    logic                                   sel_taken;
    logic                                   ccu_rdy_q;
    logic                                   rd_pend_q;
    logic                                   blk_end_q;
    logic                                   addr_xfer;
    logic                                   dat_xfer;
    logic                                   net_end;
    logic [NUM_TARGET-1:0][ADDR_WIDTH-1:0]  ptr_q;
    logic [NUM_LAYER_WIDTH-1:0]             layer_cnt_q;

    // ======================================================================
    // Target pick and FSM
    // ======================================================================
    assign tgt_rdy = {pol_rdy_i, sya_rdy_i, ccu_rdy_q};

    always_comb begin
        pick = OPC_POL;
        for (int i = NUM_TARGET - 1; i >= 0; i--) begin
            if (tgt_rdy[i]) pick = target_idx_t'(i);   // Lowest index wins
        end
    end

    always_comb begin
        case (sel_q)
            OPC_CCU: sel_taken = ccu_taken_i;
            OPC_SYA: sel_taken = sya_taken_i;
            default: sel_taken = pol_taken_i;
        endcase
    end

    assign net_end = (num_layers_i != '0) && (layer_cnt_q == num_layers_i);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:     if (start_i) state_d = ST_IDLE_CFG;
            ST_IDLE_CFG: begin
                if (net_end) state_d = ST_NET_DONE;
                else if (|tgt_rdy) state_d = ST_CFG;
            end
            ST_CFG:      if (sel_taken) state_d = ST_IDLE_CFG;
            default:     state_d = ST_IDLE;   // net_done lasts one cycle
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= ST_IDLE;
            sel_q     <= OPC_CCU;
            ccu_rdy_q <= 1'b1;
        end else begin
            state_q <= state_d;
            if (state_q == ST_IDLE_CFG && state_d == ST_CFG) sel_q <= pick;
            if (state_q == ST_IDLE) ccu_rdy_q <= 1'b1;
            else if (ccu_taken_i) ccu_rdy_q <= 1'b0;
        end
    end

    // ======================================================================
    // RAM read channels
    // ======================================================================
    assign rd_addr_vld_o = (state_q == ST_CFG) && !rd_pend_q && !blk_end_q;
    assign rd_addr_o     = ptr_q[sel_q];
    assign rd_dat_rdy_o  = rd_pend_q;
    assign addr_xfer     = rd_addr_vld_o && rd_addr_rdy_i;
    assign dat_xfer      = rd_dat_vld_i && rd_dat_rdy_o;
    assign beat_o        = '{vld: dat_xfer, word: rd_dat_i, tgt: sel_q};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_pend_q <= 1'b0;
            blk_end_q <= 1'b0;
        end else begin
            if (addr_xfer) rd_pend_q <= 1'b1;
            else if (dat_xfer) rd_pend_q <= 1'b0;
            // Stop issuing once the block is complete
            if (state_q != ST_CFG) blk_end_q <= 1'b0;
            else if (block_done_i) blk_end_q <= 1'b1;
        end
    end

    // Read pointers and layer counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr_q       <= '0;
            layer_cnt_q <= '0;
        end else if (state_q == ST_IDLE) begin
            ptr_q       <= '0;
            layer_cnt_q <= '0;
        end else begin
            if (addr_xfer) ptr_q[sel_q] <= ptr_q[sel_q] + 1'b1;
            if (sya_taken_i) layer_cnt_q <= layer_cnt_q + 1'b1;
        end
    end

    // Lowest address any target still needs
    always_comb begin
        addr_min_o = ptr_q[0];
        for (int i = 1; i < NUM_TARGET; i++) begin
            if (ptr_q[i] < addr_min_o) addr_min_o = ptr_q[i];
        end
    end

    assign tgt_rst_o  = {(NUM_TARGET - 1){state_q == ST_IDLE}};
    assign net_done_o = (state_q == ST_NET_DONE);

endmodule

`default_nettype wire

//--- source/isa_pkg.sv
// Instruction word format and fetch control types
// Opcode sits in the lowest byte of every word, fields start at bit 8
// Opcode value equals target index and arbitration priority (0 is highest)
// Blocks are at most 3 words long, so a 2-bit word counter is enough
`default_nettype none

package isa_pkg;

    // ======================================================================
    // Word and address format
    // ======================================================================
    localparam int ISA_WIDTH       = 256;
    localparam int ADDR_WIDTH      = 16;
    localparam int OPCODE_WIDTH    = 8;
    localparam int NUM_LAYER_WIDTH = 20;
    localparam int NUM_TARGET      = 3;

    typedef logic [1:0]           target_idx_t;
    typedef logic [ISA_WIDTH-1:0] isa_word_t;

    // Opcodes double as target indices
    localparam target_idx_t OPC_CCU = 2'd0;   // Unit itself, layer count
    localparam target_idx_t OPC_SYA = 2'd1;   // Systolic array
    localparam target_idx_t OPC_POL = 2'd2;   // Pool cores

    // Block length in words, indexed by opcode
    localparam logic [1:0] WORDS_PER_OPC [NUM_TARGET] = '{2'd1, 2'd1, 2'd3};

    // Accepted RAM word on its way to the decoder
    typedef struct packed {
        logic        vld;
        isa_word_t   word;
        target_idx_t tgt;   // Target the word was fetched for
    } isa_beat_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_IDLE_CFG,
        ST_CFG,
        ST_NET_DONE
    } ccu_state_t;

endpackage

`default_nettype wire

//--- src.f
+incdir+sim
source/isa_pkg.sv
source/cfg_pkg.sv
source/isa_fetch.sv
source/isa_decode.sv
source/cfg_slot.sv
source/ccu_top.sv
sim/ccu_tb.sv
